/* rtl/dino_pkg.sv */
package dino_pkg;

    // game controller states
    typedef enum logic [2:0] {
        IDLE = 3'd0,
        RUN  = 3'd1,
        OVER = 3'd2,
        WIN  = 3'd3
    } game_state_t;

    // dino motion state, y measured up from the ground line
    typedef struct packed {
        logic [7:0]        y;
        logic signed [7:0] v;
        logic              airborne;
    } dino_t;

    typedef struct packed {
        logic [8:0] x;
        logic [5:0] height;
    } cactus_t;

    // playfield geometry
    localparam logic [8:0] SCREEN_W = 9'd320;
    localparam logic [8:0] DINO_X   = 9'd40;
    localparam logic [8:0] DINO_W   = 9'd16;
    localparam logic [8:0] CACTUS_W = 9'd12;

    // pixels per frame tick
    localparam logic [8:0] CACTUS_SPEED = 9'd8;

    // jump physics
    localparam logic signed [7:0] JUMP_V  = 8'sd14;
    localparam logic signed [7:0] GRAVITY = 8'sd2;

    // cactus height = HEIGHT_MIN + HEIGHT_STEP * lfsr[1:0]
    localparam logic [5:0] HEIGHT_MIN  = 6'd10;
    localparam logic [5:0] HEIGHT_STEP = 6'd6;

    // x^8 + x^6 + x^5 + x^4 + 1, fibonacci form
    localparam logic [7:0] LFSR_SEED = 8'hA5;
    localparam logic [7:0] LFSR_TAPS = 8'hB8;

    // two bcd digits, tens in the upper nibble
    localparam logic [7:0] WIN_SCORE = 8'h20;

endpackage

/* rtl/button_sync.sv */
`timescale 1ns/100ps

module button_sync (
    input  logic clk,
    input  logic rst,
    input  logic up,
    output logic press,
    output logic held
);

    logic sync0;
    logic sync1;
    logic sync1_d;

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            sync0   <= 1'b0;
            sync1   <= 1'b0;
            sync1_d <= 1'b0;
        end else begin
            sync0   <= up;
            sync1   <= sync0;
            sync1_d <= sync1;
        end
    end

    assign held  = sync1;
    // all terms come from flops, one cycle wide
    assign press = sync1 & ~sync1_d;

endmodule

/* rtl/game_fsm.sv */
`timescale 1ns/100ps

module game_fsm import dino_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        press,
    input  logic        collides,
    input  logic        win,
    output game_state_t state
);

    game_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (press) state_next = RUN;
            end
            RUN: begin
                // reaching the score beats a hit in the same cycle
                if (win) begin
                    state_next = WIN;
                end else if (collides) begin
                    state_next = OVER;
                end
            end
            OVER, WIN: begin
                if (press) state_next = IDLE;
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (!rst)
        state inside {IDLE, RUN, OVER, WIN});

    a_win_from_run: assert property (@(posedge clk) disable iff (!rst)
        (state == WIN && $past(state) != WIN) |-> $past(state) == RUN);

endmodule

/* rtl/dino_jump.sv */
`timescale 1ns/100ps

module dino_jump import dino_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  game_state_t state,
    input  logic        tick,
    input  logic        held,
    output dino_t       dino
);

    // height after this tick, wide enough to see a drop below ground
    logic signed [9:0] y_sum;

    assign y_sum = $signed({2'b00, dino.y}) + $signed({{2{dino.v[7]}}, dino.v});

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            dino <= '0;
        end else if (state == IDLE) begin
            // standing on the ground, at rest
            dino <= '0;
        end else if (state == RUN && tick) begin
            if (!dino.airborne) begin
                if (held) begin
                    dino.v        <= JUMP_V;
                    dino.airborne <= 1'b1;
                end
            end else if (y_sum < 0) begin
                // landing
                dino.y        <= 8'd0;
                dino.v        <= 8'sd0;
                dino.airborne <= 1'b0;
            end else begin
                dino.y <= y_sum[7:0];
                dino.v <= dino.v - GRAVITY;
            end
        end
        // over and win keep the last position
    end

    a_y_needs_air: assert property (@(posedge clk) disable iff (!rst)
        dino.y != 8'd0 |-> dino.airborne);

endmodule

/* rtl/cactus_move.sv */
`timescale 1ns/100ps

module cactus_move import dino_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  game_state_t state,
    input  logic        tick,
    output cactus_t     cactus,
    output logic        passed
);

    logic [7:0] lfsr;
    logic [7:0] lfsr_next;

    // shift left with feedback into bit 0
    assign lfsr_next = {lfsr[6:0], ^(lfsr & LFSR_TAPS)};

    function automatic logic [5:0] height_of(input logic [7:0] r);
        return HEIGHT_MIN + HEIGHT_STEP * {4'd0, r[1:0]};
    endfunction

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            lfsr          <= LFSR_SEED;
            cactus.x      <= SCREEN_W;
            cactus.height <= height_of(LFSR_SEED);
            passed        <= 1'b0;
        end else begin
            passed <= 1'b0;
            case (state)
                IDLE: begin
                    // park at the right edge while the lfsr carries over between games
                    cactus.x      <= SCREEN_W;
                    cactus.height <= height_of(lfsr);
                end
                RUN: begin
                    if (tick) begin
                        if (cactus.x < CACTUS_SPEED) begin
                            // respawn with a new height once off the left edge
                            cactus.x      <= SCREEN_W;
                            cactus.height <= height_of(lfsr_next);
                            lfsr          <= lfsr_next;
                            passed        <= 1'b1;
                        end else begin
                            cactus.x <= cactus.x - CACTUS_SPEED;
                        end
                    end
                end
                default: begin
                    // frozen while the end screen is up
                    cactus <= cactus;
                end
            endcase
        end
    end

    // the all-zero lfsr state would lock up
    a_lfsr_alive: assert property (@(posedge clk) disable iff (!rst)
        lfsr != 8'd0);

endmodule

/* rtl/collision_detector.sv */
`timescale 1ns/100ps

module collision_detector import dino_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  dino_t       dino,
    input  cactus_t     cactus,
    input  game_state_t state,
    output logic        collides
);

    logic x_overlap;
    logic y_overlap;

    // half-open ranges, touching edges do not count
    assign x_overlap = (DINO_X < cactus.x + CACTUS_W) && (cactus.x < DINO_X + DINO_W);
    assign y_overlap = dino.y < {2'b00, cactus.height};

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            collides <= 1'b0;
        end else begin
            collides <= (state == RUN) && x_overlap && y_overlap;
        end
    end

    // one cycle of lag after the fsm leaves run is expected
    a_quiet_outside_run: assert property (@(posedge clk) disable iff (!rst)
        (state != RUN && $past(state) != RUN) |-> !collides);

endmodule

/* rtl/score_counter.sv */
`timescale 1ns/100ps

module score_counter import dino_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  game_state_t state,
    input  logic        passed,
    input  logic        press,
    output logic [3:0]  bcd_ones,
    output logic [3:0]  bcd_tens,
    output logic        win
);

    always_ff @(posedge clk, negedge rst) begin
        if (!rst) begin
            bcd_ones <= 4'd0;
            bcd_tens <= 4'd0;
        end else if (state == IDLE && press) begin
            // new game starting
            bcd_ones <= 4'd0;
            bcd_tens <= 4'd0;
        end else if (state == RUN && passed) begin
            if (bcd_ones == 4'd9) begin
                bcd_ones <= 4'd0;
                bcd_tens <= (bcd_tens == 4'd9) ? 4'd0 : bcd_tens + 4'd1;
            end else begin
                bcd_ones <= bcd_ones + 4'd1;
            end
        end
    end

    assign win = {bcd_tens, bcd_ones} == WIN_SCORE;

    a_digits_bcd: assert property (@(posedge clk) disable iff (!rst)
        bcd_ones <= 4'd9 && bcd_tens <= 4'd9);

endmodule

/* rtl/seg_decoder.sv */
`timescale 1ns/100ps

module seg_decoder (
    input  logic [3:0] bcd,
    output logic [6:0] seg
);

    // seg[6:0] is g f e d c b a
    always_comb begin
        case (bcd)
            4'd0:    seg = 7'h3F;
            4'd1:    seg = 7'h06;
            4'd2:    seg = 7'h5B;
            4'd3:    seg = 7'h4F;
            4'd4:    seg = 7'h66;
            4'd5:    seg = 7'h6D;
            4'd6:    seg = 7'h7D;
            4'd7:    seg = 7'h07;
            4'd8:    seg = 7'h7F;
            4'd9:    seg = 7'h6F;
            // blank for non-bcd codes
            default: seg = 7'h00;
        endcase
    end

endmodule

/* rtl/dino_game.sv */
`timescale 1ns/100ps

module dino_game import dino_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        up,
    input  logic        tick,
    output game_state_t state,
    output dino_t       dino,
    output cactus_t     cactus,
    output logic        collides,
    output logic [6:0]  ones_seg,
    output logic [6:0]  tens_seg
);

    logic       press;
    logic       held;
    logic       passed;
    logic       win;
    logic [3:0] bcd_ones;
    logic [3:0] bcd_tens;

    button_sync i_button_sync (
        .clk   (clk),
        .rst   (rst),
        .up    (up),
        .press (press),
        .held  (held)
    );

    game_fsm i_game_fsm (
        .clk      (clk),
        .rst      (rst),
        .press    (press),
        .collides (collides),
        .win      (win),
        .state    (state)
    );

    dino_jump i_dino_jump (
        .clk   (clk),
        .rst   (rst),
        .state (state),
        .tick  (tick),
        .held  (held),
        .dino  (dino)
    );

    cactus_move i_cactus_move (
        .clk    (clk),
        .rst    (rst),
        .state  (state),
        .tick   (tick),
        .cactus (cactus),
        .passed (passed)
    );

    collision_detector i_collision_detector (
        .clk      (clk),
        .rst      (rst),
        .dino     (dino),
        .cactus   (cactus),
        .state    (state),
        .collides (collides)
    );

    score_counter i_score_counter (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .passed   (passed),
        .press    (press),
        .bcd_ones (bcd_ones),
        .bcd_tens (bcd_tens),
        .win      (win)
    );

    seg_decoder i_ones_seg (
        .bcd (bcd_ones),
        .seg (ones_seg)
    );

    seg_decoder i_tens_seg (
        .bcd (bcd_tens),
        .seg (tens_seg)
    );

endmodule

/* tb/dino_game_model.svh */
`ifndef DINO_GAME_MODEL_SVH
`define DINO_GAME_MODEL_SVH

// reference state, one copy of every register in the game
logic        m_s0;
logic        m_s1;
logic        m_s1d;
game_state_t m_state;
int          m_y;
int          m_v;
logic        m_air;
int          m_x;
int          m_h;
logic [7:0]  m_lfsr;
logic        m_passed;
logic        m_collides;
int          m_score;

// x^8 + x^6 + x^5 + x^4 + 1, feedback shifted into bit 0
function automatic logic [7:0] lfsr_advance(input logic [7:0] r);
    return {r[6:0], r[7] ^ r[5] ^ r[4] ^ r[3]};
endfunction

function automatic int height_from(input logic [7:0] r);
    return 10 + 6 * int'(r[1:0]);
endfunction

// g f e d c b a, active high
function automatic logic [6:0] seg_of(input int d);
    case (d)
        0: return 7'b011_1111;
        1: return 7'b000_0110;
        2: return 7'b101_1011;
        3: return 7'b100_1111;
        4: return 7'b110_0110;
        5: return 7'b110_1101;
        6: return 7'b111_1101;
        7: return 7'b000_0111;
        8: return 7'b111_1111;
        9: return 7'b110_1111;
        default: return 7'b000_0000;
    endcase
endfunction

task automatic model_reset();
    m_s0       = 1'b0;
    m_s1       = 1'b0;
    m_s1d      = 1'b0;
    m_state    = IDLE;
    m_y        = 0;
    m_v        = 0;
    m_air      = 1'b0;
    m_x        = 320;
    m_lfsr     = 8'hA5;
    m_h        = height_from(8'hA5);
    m_passed   = 1'b0;
    m_collides = 1'b0;
    m_score    = 0;
endtask

task automatic model_step(input logic up_in, input logic tick_in);
    logic        press;
    logic        held;
    logic        won;
    logic        hit;
    logic        passed_n;
    int          ysum;
    game_state_t state_n;
    press = m_s1 && !m_s1d;
    held  = m_s1;
    won   = (m_score == 20);
    // everything below looks at the values from before this edge
    hit   = (m_state == RUN) && (40 < m_x + 12) && (m_x < 56) && (m_y < m_h);
    state_n = m_state;
    case (m_state)
        IDLE: if (press) state_n = RUN;
        RUN: begin
            if (won) state_n = WIN;
            else if (m_collides) state_n = OVER;
        end
        default: if (press) state_n = IDLE;
    endcase
    if (m_state == IDLE) begin
        m_y   = 0;
        m_v   = 0;
        m_air = 1'b0;
    end else if (m_state == RUN && tick_in) begin
        if (!m_air) begin
            if (held) begin
                m_v   = 14;
                m_air = 1'b1;
            end
        end else begin
            ysum = m_y + m_v;
            if (ysum < 0) begin
                m_y   = 0;
                m_v   = 0;
                m_air = 1'b0;
            end else begin
                m_y = ysum;
                m_v = m_v - 2;
            end
        end
    end
    passed_n = 1'b0;
    if (m_state == IDLE) begin
        m_x = 320;
        m_h = height_from(m_lfsr);
    end else if (m_state == RUN && tick_in) begin
        if (m_x < 8) begin
            m_lfsr   = lfsr_advance(m_lfsr);
            m_x      = 320;
            m_h      = height_from(m_lfsr);
            passed_n = 1'b1;
        end else begin
            m_x = m_x - 8;
        end
    end
    if (m_state == IDLE && press) m_score = 0;
    else if (m_state == RUN && m_passed) m_score = (m_score + 1) % 100;
    m_s1d      = m_s1;
    m_s1       = m_s0;
    m_s0       = up_in;
    m_passed   = passed_n;
    m_collides = hit;
    m_state    = state_n;
endtask

`endif

/* tb/tb_dino_game.sv */
`timescale 1ns/100ps

module tb_dino_game import dino_pkg::*; ();

    // cycle budget over all tests for the watchdog
    localparam int TOTAL_CYCLES = 6000;
    localparam int PERIOD_NS    = 4;

    logic        clk;
    logic        rst;
    logic        up;
    logic        tick;
    game_state_t state;
    dino_t       dino;
    cactus_t     cactus;
    logic        collides;
    logic [6:0]  ones_seg;
    logic [6:0]  tens_seg;
    integer      seed;
    string       test_name;

    `include "dino_game_model.svh"

    dino_game i_dino_game (
        .clk      (clk),
        .rst      (rst),
        .up       (up),
        .tick     (tick),
        .state    (state),
        .dino     (dino),
        .cactus   (cactus),
        .collides (collides),
        .ones_seg (ones_seg),
        .tens_seg (tens_seg)
    );

    always #(PERIOD_NS / 2) clk = ~clk;

    always @(posedge clk, negedge rst) begin
        if (!rst) model_reset();
        else model_step(up, tick);
    end

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("error: test %s, %s expected %h actual %h", test_name, what, exp, act);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    // outputs are compared half a period after the rising edge
    always @(negedge clk) begin
        assert (state === m_state)
            else report_mismatch("state", 32'(m_state), 32'(state));
        assert (dino === {8'(m_y), 8'(m_v), m_air})
            else report_mismatch("dino", 32'({8'(m_y), 8'(m_v), m_air}), 32'(dino));
        assert (cactus === {9'(m_x), 6'(m_h)})
            else report_mismatch("cactus", 32'({9'(m_x), 6'(m_h)}), 32'(cactus));
        assert (collides === m_collides)
            else report_mismatch("collides", 32'(m_collides), 32'(collides));
        assert (ones_seg === seg_of(m_score % 10))
            else report_mismatch("ones_seg", 32'(seg_of(m_score % 10)), 32'(ones_seg));
        assert (tens_seg === seg_of(m_score / 10))
            else report_mismatch("tens_seg", 32'(seg_of(m_score / 10)), 32'(tens_seg));
    end

    task automatic drive(input logic up_v, input logic tick_v);
        @(negedge clk);
        up   = up_v;
        tick = tick_v;
    endtask

    task automatic press_button();
        repeat (3) drive(1'b1, 1'b0);
        repeat (3) drive(1'b0, 1'b0);
    endtask

    task automatic start_game();
        while (m_state != RUN) press_button();
    endtask

    // short press at cactus x 128 so the jump peaks over it
    task automatic dodge_cycle();
        drive(m_state == RUN && m_x == 128, 1'b1);
    endtask

    initial begin
        #(TOTAL_CYCLES * PERIOD_NS + 1000 * PERIOD_NS);
        $display("error: watchdog expired during test %s, the run did not finish", test_name);
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        up        = 1'b0;
        tick      = 1'b0;
        seed      = 32'hbca4_d206;
        test_name = "reset_idle";
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        repeat (40) drive(1'b0, 1'($random(seed)));

        test_name = "jump_arc";
        start_game();
        drive(1'b1, 1'b1);
        repeat (20) drive(1'b0, 1'b1);
        @(negedge clk);
        assert (dino.y == 8'd0 && !dino.airborne)
            else report_mismatch("landed dino", 32'd0, 32'(dino));

        test_name = "cactus_scroll";
        while (m_score < 3) dodge_cycle();

        test_name = "score_win";
        while (m_state != WIN) dodge_cycle();
        start_game();
        repeat (5) drive(1'b0, 1'b0);
        assert (ones_seg == seg_of(0) && tens_seg == seg_of(0))
            else report_mismatch("cleared score", 32'({seg_of(0), seg_of(0)}),
                                 32'({tens_seg, ones_seg}));

        test_name = "collision";
        while (m_state != OVER) drive(1'b0, 1'b1);
        repeat (10) drive(1'b0, 1'($random(seed)));
        press_button();
        assert (state == IDLE)
            else report_mismatch("state after press", 32'(IDLE), 32'(state));

        test_name = "random_games";
        repeat (3000) begin
            // rare toggles keep the button level for long stretches
            if (($random(seed) & 15) == 0) drive(~up, 1'($random(seed)));
            else drive(up, 1'($random(seed)));
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+tb
rtl/dino_pkg.sv
rtl/button_sync.sv
rtl/game_fsm.sv
rtl/dino_jump.sv
rtl/cactus_move.sv
rtl/collision_detector.sv
rtl/score_counter.sv
rtl/seg_decoder.sv
rtl/dino_game.sv
tb/tb_dino_game.sv

/* run.sh */
#!/bin/sh
# build and run the dino game testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_dino_game -o sim_dino_game
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_dino_game
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi
exit 0
